//--- include/vec_alu_params.svh
/*
 * vector ALU sizing, shared by the package and every RTL block
 */

`ifndef VEC_ALU_PARAMS_SVH
`define VEC_ALU_PARAMS_SVH

// ============================================================
// vector shape
// ============================================================

// lanes per vector word
`define VEC_LANES 4

// result lane, also the register file and temp buffer lane
`define TMP_BW 16

// SRAM operand lanes and DRAM write lanes
`define DATA_BW 8

// ============================================================
// storage sizes
// ============================================================

// vector registers
`define REG_DEPTH 16

// words buffered per operand stream
`define STREAM_DEPTH 4

`endif

//--- source/vec_alu_pkg.sv
/*
 * vector ALU package: opcode, operand source and logic subop
 * encodings, plus the lane types
 */

`default_nettype none

`include "vec_alu_params.svh"

package vec_alu_pkg;

	// ============================================================
	// instruction encodings
	// ============================================================

	// 5 and 7 are reserved and compute zero
	typedef enum logic [2:0] {
		ADD     = 3'd0,
		SUB     = 3'd1,
		SQDIFF  = 3'd2,
		ABSDIFF = 3'd3,
		MAC     = 3'd4,
		LOGIC   = 3'd6
	} alu_op_e;

	// where an operand comes from
	typedef enum logic [2:0] {
		CONST = 3'd0,
		REG   = 3'd1,
		STRM0 = 3'd2,
		STRM1 = 3'd3,
		TMP0  = 3'd4,
		TMP1  = 3'd5
	} opnd_src_e;

	// LOGIC subop rides in the shamt field
	typedef enum logic [4:0] {
		SELZ = 5'd0,
		MAX  = 5'd2,
		MIN  = 5'd3
	} logic_sub_e;

	// ============================================================
	// lane types
	// ============================================================
	typedef logic signed [`TMP_BW-1:0] lane_t;
	typedef logic [`DATA_BW-1:0] data_lane_t;

endpackage

`default_nettype wire

//--- source/lane_fifo.sv
/*
 * operand stream FIFO: buffers SRAM vector words and offers
 * the head word over rdy/ack
 */

`timescale 1ns/1ps
`default_nettype none

`include "vec_alu_params.svh"

module lane_fifo (
	input  wire                      i_clk,
	input  wire                      i_rst_n,
	input  wire                      i_push,
	input  wire vec_alu_pkg::data_lane_t i_push_data [`VEC_LANES],
	output logic                     o_full,
	output logic                     o_rdy,
	input  wire                      i_ack,
	output vec_alu_pkg::data_lane_t  o_head [`VEC_LANES]
);

	localparam int DEPTH  = `STREAM_DEPTH;
	localparam int PTR_BW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BW = $clog2(DEPTH + 1);

	vec_alu_pkg::data_lane_t mem [DEPTH][`VEC_LANES];
	logic [PTR_BW-1:0] wr_ptr;
	logic [PTR_BW-1:0] rd_ptr;
	logic [CNT_BW-1:0] count;
	logic do_push;
	logic do_pop;

	function automatic logic [PTR_BW-1:0] next_ptr(input logic [PTR_BW-1:0] ptr);
		next_ptr = (ptr == PTR_BW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// a push into a full FIFO is dropped
	assign do_push = i_push && !o_full;
	assign do_pop  = i_ack && o_rdy;
	assign o_full  = (count == CNT_BW'(DEPTH));
	assign o_rdy   = (count != '0);
	assign o_head  = mem[rd_ptr];

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= next_ptr(wr_ptr);
			if (do_pop) rd_ptr <= next_ptr(rd_ptr);
			if (do_push && !do_pop) count <= count + 1'b1;
			else if (do_pop && !do_push) count <= count - 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (do_push) mem[wr_ptr] <= i_push_data;
	end

endmodule

`default_nettype wire

//--- source/vec_regfile.sv
/*
 * vector register file, one combinational read port and
 * one clocked write port
 */

`timescale 1ns/1ps
`default_nettype none

`include "vec_alu_params.svh"

module vec_regfile #(
	parameter int ABW = $clog2(`REG_DEPTH)
) (
	input  wire                      i_clk,
	input  wire                      i_rst_n,
	input  wire [ABW-1:0]            i_raddr,
	output vec_alu_pkg::lane_t       o_rdata [`VEC_LANES],
	input  wire                      i_we,
	input  wire [ABW-1:0]            i_waddr,
	input  wire vec_alu_pkg::lane_t  i_wdata [`VEC_LANES]
);

	vec_alu_pkg::lane_t regs [`REG_DEPTH][`VEC_LANES];

	// read is visible in the cycle after a write lands
	assign o_rdata = regs[i_raddr];

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int r = 0; r < `REG_DEPTH; r++) begin
				for (int l = 0; l < `VEC_LANES; l++) begin
					regs[r][l] <= '0;
				end
			end
		end else if (i_we) begin
			regs[i_waddr] <= i_wdata;
		end
	end

endmodule

`default_nettype wire

//--- source/temp_buf.sv
/*
 * two-entry result delay line, lets an instruction chain on the
 * previous and the second-previous result
 */

`timescale 1ns/1ps
`default_nettype none

`include "vec_alu_params.svh"

module temp_buf (
	input  wire                      i_clk,
	input  wire                      i_rst_n,
	input  wire                      i_we,
	input  wire vec_alu_pkg::lane_t  i_wdata [`VEC_LANES],
	output vec_alu_pkg::lane_t       o_tmp0 [`VEC_LANES],
	output vec_alu_pkg::lane_t       o_tmp1 [`VEC_LANES]
);

	// ============================================================
	// shift on write
	// ============================================================

	// entry 0 is the newest result, entry 1 the one before it
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int l = 0; l < `VEC_LANES; l++) begin
				o_tmp0[l] <= '0;
				o_tmp1[l] <= '0;
			end
		end else if (i_we) begin
			for (int l = 0; l < `VEC_LANES; l++) begin
				o_tmp1[l] <= o_tmp0[l];
				o_tmp0[l] <= i_wdata[l];
			end
		end
	end

	// nothing moves without a write, so a
	// stalled instruction sees stable operands

endmodule

`default_nettype wire

//--- source/vec_alu.sv
/*
 * vector ALU: picks three operands per lane, runs one lane-wise
 * operation and commits over the rdy/ack handshakes
 */

`timescale 1ns/1ps
`default_nettype none

`include "vec_alu_params.svh"

module vec_alu (
	input  wire                          i_op_rdy,
	output logic                         o_op_ack,
	input  wire [2:0]                    i_opcode,
	input  wire [4:0]                    i_shamt,
	input  wire [2:0]                    i_src_a,
	input  wire [2:0]                    i_src_b,
	input  wire [2:0]                    i_src_c,
	input  wire vec_alu_pkg::lane_t      i_const_a,
	input  wire vec_alu_pkg::lane_t      i_const_b,
	input  wire vec_alu_pkg::lane_t      i_const_c,
	input  wire                          i_to_reg,
	input  wire                          i_to_temp,
	input  wire                          i_to_dram,
	input  wire vec_alu_pkg::lane_t      i_rdata [`VEC_LANES],
	input  wire vec_alu_pkg::lane_t      i_tmp0 [`VEC_LANES],
	input  wire vec_alu_pkg::lane_t      i_tmp1 [`VEC_LANES],
	input  wire                          i_s0_rdy,
	output logic                         o_s0_ack,
	input  wire vec_alu_pkg::data_lane_t i_s0_data [`VEC_LANES],
	input  wire                          i_s1_rdy,
	output logic                         o_s1_ack,
	input  wire vec_alu_pkg::data_lane_t i_s1_data [`VEC_LANES],
	output logic                         o_reg_we,
	output logic                         o_tbuf_we,
	output vec_alu_pkg::lane_t           o_wdata [`VEC_LANES],
	output logic                         o_dramwd_rdy,
	input  wire                          i_dramwd_ack,
	output vec_alu_pkg::data_lane_t      o_dramwd [`VEC_LANES],
	output logic                         o_inst_commit
);

	vec_alu_pkg::alu_op_e    op;
	vec_alu_pkg::opnd_src_e  src_a;
	vec_alu_pkg::opnd_src_e  src_b;
	vec_alu_pkg::opnd_src_e  src_c;
	vec_alu_pkg::lane_t      opa [`VEC_LANES];
	vec_alu_pkg::lane_t      opb [`VEC_LANES];
	vec_alu_pkg::lane_t      opc [`VEC_LANES];
	logic need_s0;
	logic need_s1;
	logic data_rdy;
	logic commit;

	// ============================================================
	// operand select, one lane
	// ============================================================
	function automatic vec_alu_pkg::lane_t sel_lane(
		input vec_alu_pkg::opnd_src_e  src,
		input vec_alu_pkg::lane_t      cval,
		input vec_alu_pkg::lane_t      rval,
		input vec_alu_pkg::lane_t      t0,
		input vec_alu_pkg::lane_t      t1,
		input vec_alu_pkg::data_lane_t s0,
		input vec_alu_pkg::data_lane_t s1
	);
		case (src)
			vec_alu_pkg::CONST: sel_lane = cval;
			vec_alu_pkg::REG:   sel_lane = rval;
			// stream lanes are sign extended
			vec_alu_pkg::STRM0: sel_lane = $signed(s0);
			vec_alu_pkg::STRM1: sel_lane = $signed(s1);
			vec_alu_pkg::TMP0:  sel_lane = t0;
			vec_alu_pkg::TMP1:  sel_lane = t1;
			default:            sel_lane = '0;
		endcase
	endfunction

	// ============================================================
	// lane compute
	// ============================================================
	function automatic vec_alu_pkg::lane_t lane_op(
		input vec_alu_pkg::alu_op_e op_i,
		input logic [4:0]           shamt,
		input vec_alu_pkg::lane_t   a,
		input vec_alu_pkg::lane_t   b,
		input vec_alu_pkg::lane_t   c
	);
		logic signed [`DATA_BW-1:0]   d8;
		logic signed [2*`DATA_BW-1:0] prod;
		vec_alu_pkg::lane_t           d16;
		vec_alu_pkg::lane_t           term;
		// narrow difference wraps at DATA_BW before squaring
		d8  = b[`DATA_BW-1:0] - c[`DATA_BW-1:0];
		d16 = b - c;
		case (op_i)
			vec_alu_pkg::ADD: begin
				term = b + c;
				lane_op = a + (term >>> shamt);
			end
			vec_alu_pkg::SUB: lane_op = a + (d16 >>> shamt);
			vec_alu_pkg::SQDIFF: begin
				prod = d8 * d8;
				term = prod >>> shamt;
				lane_op = a + term;
			end
			vec_alu_pkg::ABSDIFF: begin
				term = (d16 < 0) ? -d16 : d16;
				lane_op = a + (term >>> shamt);
			end
			vec_alu_pkg::MAC: begin
				prod = $signed(b[`DATA_BW-1:0]) * $signed(c[`DATA_BW-1:0]);
				term = prod >>> shamt;
				lane_op = a + term;
			end
			vec_alu_pkg::LOGIC: begin
				case (vec_alu_pkg::logic_sub_e'(shamt))
					vec_alu_pkg::SELZ: lane_op = (a == 0) ? b : c;
					vec_alu_pkg::MAX:  lane_op = (b > c) ? b : c;
					vec_alu_pkg::MIN:  lane_op = (b < c) ? b : c;
					default:           lane_op = '0;
				endcase
			end
			// reserved opcodes
			default: lane_op = '0;
		endcase
	endfunction

	assign op    = vec_alu_pkg::alu_op_e'(i_opcode);
	assign src_a = vec_alu_pkg::opnd_src_e'(i_src_a);
	assign src_b = vec_alu_pkg::opnd_src_e'(i_src_b);
	assign src_c = vec_alu_pkg::opnd_src_e'(i_src_c);

	always_comb begin
		for (int i = 0; i < `VEC_LANES; i++) begin
			opa[i] = sel_lane(src_a, i_const_a, i_rdata[i], i_tmp0[i], i_tmp1[i],
				i_s0_data[i], i_s1_data[i]);
			opb[i] = sel_lane(src_b, i_const_b, i_rdata[i], i_tmp0[i], i_tmp1[i],
				i_s0_data[i], i_s1_data[i]);
			opc[i] = sel_lane(src_c, i_const_c, i_rdata[i], i_tmp0[i], i_tmp1[i],
				i_s0_data[i], i_s1_data[i]);
			o_wdata[i]  = lane_op(op, i_shamt, opa[i], opb[i], opc[i]);
			o_dramwd[i] = o_wdata[i][`DATA_BW-1:0];
		end
	end

	// ============================================================
	// handshake
	// ============================================================

	// a stream is popped once even if several operands read it
	assign need_s0 = (src_a == vec_alu_pkg::STRM0) || (src_b == vec_alu_pkg::STRM0) ||
		(src_c == vec_alu_pkg::STRM0);
	assign need_s1 = (src_a == vec_alu_pkg::STRM1) || (src_b == vec_alu_pkg::STRM1) ||
		(src_c == vec_alu_pkg::STRM1);
	assign data_rdy = i_op_rdy && (!need_s0 || i_s0_rdy) && (!need_s1 || i_s1_rdy);

	// DRAM writes hold everything until the write is taken
	assign o_dramwd_rdy = data_rdy && i_to_dram;
	assign commit = i_to_dram ? (data_rdy && i_dramwd_ack) : data_rdy;

	assign o_op_ack      = commit;
	assign o_inst_commit = commit;
	assign o_reg_we      = commit && i_to_reg;
	assign o_tbuf_we     = commit && i_to_temp;
	assign o_s0_ack      = commit && need_s0;
	assign o_s1_ack      = commit && need_s1;

endmodule

`default_nettype wire

//--- source/vec_alu_top.sv
/*
 * vector ALU stage top: ALU, two operand stream FIFOs,
 * register file and temp buffer
 */

`timescale 1ns/1ps
`default_nettype none

`include "vec_alu_params.svh"

module vec_alu_top #(
	parameter int ABW = $clog2(`REG_DEPTH)
) (
	input  wire                          i_clk,
	input  wire                          i_rst_n,
	// instruction
	input  wire                          i_op_rdy,
	input  wire [2:0]                    i_opcode,
	input  wire [4:0]                    i_shamt,
	input  wire [2:0]                    i_src_a,
	input  wire [2:0]                    i_src_b,
	input  wire [2:0]                    i_src_c,
	input  wire vec_alu_pkg::lane_t      i_const_a,
	input  wire vec_alu_pkg::lane_t      i_const_b,
	input  wire vec_alu_pkg::lane_t      i_const_c,
	input  wire                          i_to_reg,
	input  wire                          i_to_temp,
	input  wire                          i_to_dram,
	input  wire [ABW-1:0]                i_reg_raddr,
	input  wire [ABW-1:0]                i_reg_waddr,
	// operand streams
	input  wire                          i_s0_push,
	input  wire vec_alu_pkg::data_lane_t i_s0_data [`VEC_LANES],
	output logic                         o_s0_full,
	input  wire                          i_s1_push,
	input  wire vec_alu_pkg::data_lane_t i_s1_data [`VEC_LANES],
	output logic                         o_s1_full,
	// DRAM write
	output logic                         o_dramwd_rdy,
	input  wire                          i_dramwd_ack,
	output vec_alu_pkg::data_lane_t      o_dramwd [`VEC_LANES],
	// status and result
	output logic                         o_op_ack,
	output logic                         o_inst_commit,
	output logic                         o_reg_we,
	output logic [ABW-1:0]               o_reg_waddr,
	output vec_alu_pkg::lane_t           o_wdata [`VEC_LANES]
);

	logic s0_rdy;
	logic s0_ack;
	logic s1_rdy;
	logic s1_ack;
	logic tbuf_we;
	vec_alu_pkg::data_lane_t s0_head [`VEC_LANES];
	vec_alu_pkg::data_lane_t s1_head [`VEC_LANES];
	vec_alu_pkg::lane_t rdata [`VEC_LANES];
	vec_alu_pkg::lane_t tmp0 [`VEC_LANES];
	vec_alu_pkg::lane_t tmp1 [`VEC_LANES];

	assign o_reg_waddr = i_reg_waddr;

	lane_fifo u_s0_fifo (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_push(i_s0_push), .i_push_data(i_s0_data),
		.o_full(o_s0_full), .o_rdy(s0_rdy), .i_ack(s0_ack), .o_head(s0_head)
	);

	lane_fifo u_s1_fifo (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_push(i_s1_push), .i_push_data(i_s1_data),
		.o_full(o_s1_full), .o_rdy(s1_rdy), .i_ack(s1_ack), .o_head(s1_head)
	);

	vec_regfile #(.ABW(ABW)) u_regfile (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_raddr(i_reg_raddr), .o_rdata(rdata),
		.i_we(o_reg_we), .i_waddr(i_reg_waddr), .i_wdata(o_wdata)
	);

	temp_buf u_temp_buf (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_we(tbuf_we), .i_wdata(o_wdata),
		.o_tmp0(tmp0), .o_tmp1(tmp1)
	);

	vec_alu u_alu (
		.i_op_rdy(i_op_rdy), .o_op_ack(o_op_ack),
		.i_opcode(i_opcode), .i_shamt(i_shamt),
		.i_src_a(i_src_a), .i_src_b(i_src_b), .i_src_c(i_src_c),
		.i_const_a(i_const_a), .i_const_b(i_const_b), .i_const_c(i_const_c),
		.i_to_reg(i_to_reg), .i_to_temp(i_to_temp), .i_to_dram(i_to_dram),
		.i_rdata(rdata), .i_tmp0(tmp0), .i_tmp1(tmp1),
		.i_s0_rdy(s0_rdy), .o_s0_ack(s0_ack), .i_s0_data(s0_head),
		.i_s1_rdy(s1_rdy), .o_s1_ack(s1_ack), .i_s1_data(s1_head),
		.o_reg_we(o_reg_we), .o_tbuf_we(tbuf_we), .o_wdata(o_wdata),
		.o_dramwd_rdy(o_dramwd_rdy), .i_dramwd_ack(i_dramwd_ack), .o_dramwd(o_dramwd),
		.o_inst_commit(o_inst_commit)
	);

endmodule

`default_nettype wire

//--- verif/tb_clkgen.sv
/*
 * testbench clock source, free running from time zero
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
	parameter int PERIOD_NS = 20
) (
	output logic o_clk
);

	initial begin
		o_clk = 1'b0;
	end

	always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

`default_nettype wire

//--- verif/tb_vec_alu_top.sv
/*
 * vector ALU stage testbench: lane model of registers, temp buffer
 * and streams, checked by assertions on every commit
 */

`timescale 1ns/1ps
`default_nettype none

`include "vec_alu_params.svh"

module tb_vec_alu_top;

	localparam int NUM_INSTR   = 60;
	localparam int STALL_BOUND = 12;
	localparam int TIMEOUT_NS  = (NUM_INSTR * STALL_BOUND + 40) * 20;

	logic clk;
	logic rst_n;
	logic op_rdy;
	logic [2:0] opcode;
	logic [4:0] shamt;
	logic [2:0] src_a;
	logic [2:0] src_b;
	logic [2:0] src_c;
	vec_alu_pkg::lane_t const_a;
	vec_alu_pkg::lane_t const_b;
	vec_alu_pkg::lane_t const_c;
	logic to_reg;
	logic to_temp;
	logic to_dram;
	logic [3:0] reg_raddr;
	logic [3:0] reg_waddr;
	logic s0_push;
	logic s1_push;
	vec_alu_pkg::data_lane_t s0_data [`VEC_LANES];
	vec_alu_pkg::data_lane_t s1_data [`VEC_LANES];
	logic dramwd_ack;
	logic s0_full;
	logic s1_full;
	logic dramwd_rdy;
	vec_alu_pkg::data_lane_t dramwd [`VEC_LANES];
	logic op_ack;
	logic inst_commit;
	logic reg_we;
	logic [3:0] dut_waddr;
	vec_alu_pkg::lane_t wdata [`VEC_LANES];

	// model state
	vec_alu_pkg::lane_t regs_m [`REG_DEPTH][`VEC_LANES];
	vec_alu_pkg::lane_t tmp0_m [`VEC_LANES];
	vec_alu_pkg::lane_t tmp1_m [`VEC_LANES];
	vec_alu_pkg::lane_t exp_res [`VEC_LANES];
	logic [31:0] q0 [$];
	logic [31:0] q1 [$];
	integer seed;

	tb_clkgen #(.PERIOD_NS(20)) u_clkgen (.o_clk(clk));

	vec_alu_top i_dut (
		.i_clk(clk), .i_rst_n(rst_n), .i_op_rdy(op_rdy), .i_opcode(opcode), .i_shamt(shamt),
		.i_src_a(src_a), .i_src_b(src_b), .i_src_c(src_c),
		.i_const_a(const_a), .i_const_b(const_b), .i_const_c(const_c),
		.i_to_reg(to_reg), .i_to_temp(to_temp), .i_to_dram(to_dram),
		.i_reg_raddr(reg_raddr), .i_reg_waddr(reg_waddr),
		.i_s0_push(s0_push), .i_s0_data(s0_data), .o_s0_full(s0_full),
		.i_s1_push(s1_push), .i_s1_data(s1_data), .o_s1_full(s1_full),
		.o_dramwd_rdy(dramwd_rdy), .i_dramwd_ack(dramwd_ack), .o_dramwd(dramwd),
		.o_op_ack(op_ack), .o_inst_commit(inst_commit),
		.o_reg_we(reg_we), .o_reg_waddr(dut_waddr), .o_wdata(wdata)
	);

	// ============================================================
	// checks
	// ============================================================
	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			$display("Error at %0t ns: %s", $time, what);
			$display("SOME TESTS FAILED");
			$fatal(1, "condition check failed");
		end
	endtask

	// ============================================================
	// reference model
	// ============================================================
	function automatic vec_alu_pkg::lane_t fetch_opnd(input logic [2:0] src, input int lane,
		input vec_alu_pkg::lane_t cval);
		logic [31:0] w;
		logic signed [7:0] n8;
		w = 32'h0;
		case (src)
			vec_alu_pkg::CONST: return cval;
			vec_alu_pkg::REG:   return regs_m[reg_raddr][lane];
			vec_alu_pkg::TMP0:  return tmp0_m[lane];
			vec_alu_pkg::TMP1:  return tmp1_m[lane];
			vec_alu_pkg::STRM0: if (q0.size() > 0) w = q0[0];
			vec_alu_pkg::STRM1: if (q1.size() > 0) w = q1[0];
			default:            return '0;
		endcase
		n8 = w[lane*8 +: 8];
		return n8;
	endfunction

	function automatic vec_alu_pkg::lane_t calc_lane(input logic [2:0] op, input logic [4:0] sh,
		input vec_alu_pkg::lane_t a, input vec_alu_pkg::lane_t b, input vec_alu_pkg::lane_t c);
		integer t;
		logic signed [15:0] w16;
		logic signed [7:0] nb;
		logic signed [7:0] nc;
		t = 0;
		nb = b[7:0];
		nc = c[7:0];
		case (op)
			3'd0: w16 = b + c;
			3'd1: w16 = b - c;
			3'd2: begin
				nb = nb - nc;
				w16 = nb * nb;
			end
			3'd3: begin
				t = b - c;
				w16 = t;
				t = w16;
				// abs of the most negative lane wraps back to itself
				w16 = (t < 0) ? -t : t;
			end
			3'd4: w16 = nb * nc;
			3'd6: begin
				case (sh)
					5'd0: return (a == 16'sd0) ? b : c;
					5'd2: return (b > c) ? b : c;
					5'd3: return (b < c) ? b : c;
					default: return '0;
				endcase
			end
			default: return '0;
		endcase
		t = w16;
		t = t >>> sh;
		return a + t;
	endfunction

	function automatic logic uses_src(input logic [2:0] s);
		return (src_a == s) || (src_b == s) || (src_c == s);
	endfunction

	task automatic compute_expected();
		for (int l = 0; l < `VEC_LANES; l++) begin
			exp_res[l] = calc_lane(opcode, shamt, fetch_opnd(src_a, l, const_a),
				fetch_opnd(src_b, l, const_b), fetch_opnd(src_c, l, const_c));
		end
	endtask

	// ============================================================
	// stimulus helpers, entered on a falling edge
	// ============================================================
	task automatic drive_instr(input logic [2:0] op, input logic [4:0] sh,
		input logic [2:0] sa, input logic [2:0] sb, input logic [2:0] sc,
		input logic treg, input logic ttemp, input logic tdram);
		opcode  = op;
		shamt   = sh;
		src_a   = sa;
		src_b   = sb;
		src_c   = sc;
		const_a = $random(seed);
		const_b = $random(seed);
		const_c = $random(seed);
		to_reg  = treg;
		to_temp = ttemp;
		to_dram = tdram;
		reg_raddr = $random(seed);
		reg_waddr = $random(seed);
		op_rdy  = 1'b1;
	endtask

	task automatic push_word(input int s, input logic [31:0] w);
		for (int l = 0; l < `VEC_LANES; l++) begin
			s0_data[l] = w[l*8 +: 8];
			s1_data[l] = w[l*8 +: 8];
		end
		if (s == 0) begin
			s0_push = 1'b1;
			if (q0.size() < `STREAM_DEPTH) q0.push_back(w);
		end else begin
			s1_push = 1'b1;
			if (q1.size() < `STREAM_DEPTH) q1.push_back(w);
		end
		@(negedge clk);
		s0_push = 1'b0;
		s1_push = 1'b0;
	endtask

	task automatic check_outputs();
		check_val("o_op_ack", op_ack, 1);
		check_val("o_reg_we", reg_we, to_reg);
		check_val("o_reg_waddr", dut_waddr, reg_waddr);
		for (int l = 0; l < `VEC_LANES; l++) begin
			check_val($sformatf("o_wdata[%0d]", l), wdata[l], exp_res[l]);
			if (to_dram) begin
				check_val($sformatf("o_dramwd[%0d]", l), dramwd[l], exp_res[l][7:0]);
			end
		end
	endtask

	// sample mid cycle, commit takes effect at the next rising edge
	task automatic wait_commit();
		logic done;
		logic pop0;
		logic pop1;
		done = 1'b0;
		while (!done) begin
			#5;
			compute_expected();
			if (inst_commit) begin
				check_outputs();
				done = 1'b1;
			end else begin
				check_true(!(to_dram && dramwd_ack), "no commit in the cycle of dramwd_ack");
				@(negedge clk);
			end
		end
		pop0 = uses_src(vec_alu_pkg::STRM0);
		pop1 = uses_src(vec_alu_pkg::STRM1);
		@(posedge clk);
		if (to_reg) regs_m[reg_waddr] = exp_res;
		if (to_temp) begin
			tmp1_m = tmp0_m;
			tmp0_m = exp_res;
		end
		if (pop0) void'(q0.pop_front());
		if (pop1) void'(q1.pop_front());
		@(negedge clk);
		op_rdy     = 1'b0;
		dramwd_ack = 1'b0;
	endtask

	task automatic check_no_commit(input string what);
		#5;
		check_true(!inst_commit && !op_ack && !reg_we, what);
	endtask

	function automatic logic [2:0] pick_src(input logic with_tmp);
		int r;
		r = {$random(seed)} % 4;
		if (!with_tmp) return (r < 2) ? vec_alu_pkg::CONST : vec_alu_pkg::REG;
		case (r)
			0: return vec_alu_pkg::CONST;
			1: return vec_alu_pkg::REG;
			2: return vec_alu_pkg::TMP0;
			default: return vec_alu_pkg::TMP1;
		endcase
	endfunction

	// ============================================================
	// watchdog
	// ============================================================
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	// ============================================================
	// main sequence
	// ============================================================
	initial begin
		seed = 23864;
		rst_n = 1'b0;
		op_rdy = 1'b0;
		opcode = '0;
		shamt = '0;
		src_a = '0;
		src_b = '0;
		src_c = '0;
		const_a = '0;
		const_b = '0;
		const_c = '0;
		to_reg = 1'b0;
		to_temp = 1'b0;
		to_dram = 1'b0;
		reg_raddr = '0;
		reg_waddr = '0;
		s0_push = 1'b0;
		s1_push = 1'b0;
		dramwd_ack = 1'b0;
		for (int l = 0; l < `VEC_LANES; l++) begin
			s0_data[l] = '0;
			s1_data[l] = '0;
			tmp0_m[l] = '0;
			tmp1_m[l] = '0;
			for (int r = 0; r < `REG_DEPTH; r++) regs_m[r][l] = '0;
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// idle after reset
		repeat (4) begin
			check_no_commit("commit or write seen while op_rdy was low");
			check_true(!dramwd_rdy, "dramwd_rdy high while op_rdy was low");
			@(negedge clk);
		end

		// arithmetic with constant and register operands
		repeat (24) begin
			drive_instr({$random(seed)} % 5, {$random(seed)} % 4, pick_src(0), pick_src(0),
				pick_src(0), 1'b1, {$random(seed)} % 2, 1'b0);
			wait_commit();
		end
		repeat (4) begin
			drive_instr(vec_alu_pkg::ADD, 0, vec_alu_pkg::REG, vec_alu_pkg::CONST,
				vec_alu_pkg::CONST, 1'b0, 1'b0, 1'b0);
			const_b = '0;
			const_c = '0;
			wait_commit();
		end

		// stall on an empty stream, then commit after a push
		drive_instr(vec_alu_pkg::ADD, 0, vec_alu_pkg::CONST, vec_alu_pkg::STRM0,
			vec_alu_pkg::STRM0, 1'b1, 1'b0, 1'b0);
		repeat (3) begin
			check_no_commit("commit while stream 0 was empty");
			@(negedge clk);
		end
		push_word(0, $random(seed));
		wait_commit();

		// order, a full FIFO and a single pop per commit
		for (int i = 0; i < 4; i++) push_word(0, $random(seed));
		for (int i = 0; i < 4; i++) push_word(1, $random(seed));
		check_true(s0_full, "stream 0 not full after four pushes");
		check_true(s1_full, "stream 1 not full after four pushes");
		push_word(0, $random(seed));
		for (int i = 0; i < 3; i++) begin
			drive_instr(vec_alu_pkg::MAC, i, vec_alu_pkg::STRM0, vec_alu_pkg::STRM0,
				vec_alu_pkg::STRM1, 1'b1, 1'b1, 1'b0);
			wait_commit();
		end
		drive_instr(vec_alu_pkg::SQDIFF, 1, vec_alu_pkg::CONST, vec_alu_pkg::STRM0,
			vec_alu_pkg::STRM1, 1'b1, 1'b0, 1'b0);
		wait_commit();
		check_true(!s0_full, "stream 0 still full after pops");
		check_true(!s1_full, "stream 1 still full after pops");

		// chaining through the temp buffer
		repeat (10) begin
			drive_instr({$random(seed)} % 5, {$random(seed)} % 3, pick_src(1), pick_src(1),
				pick_src(1), {$random(seed)} % 2, 1'b1, 1'b0);
			wait_commit();
		end

		// DRAM back-pressure, with and without stream data held
		for (int i = 0; i < 2; i++) begin
			if (i == 1) push_word(1, $random(seed));
			drive_instr(vec_alu_pkg::ABSDIFF, 0, vec_alu_pkg::CONST,
				(i == 1) ? vec_alu_pkg::STRM1 : vec_alu_pkg::CONST, vec_alu_pkg::REG,
				1'b0, 1'b1, 1'b1);
			repeat (4) begin
				check_no_commit("commit before dramwd_ack");
				compute_expected();
				check_val("o_dramwd_rdy", dramwd_rdy, 1);
				for (int l = 0; l < `VEC_LANES; l++) begin
					check_val($sformatf("o_dramwd[%0d]", l), dramwd[l], exp_res[l][7:0]);
				end
				@(negedge clk);
			end
			dramwd_ack = 1'b1;
			wait_commit();
		end

		// LOGIC subops and a reserved opcode
		for (int i = 0; i < 6; i++) begin
			case (i)
				0, 1: shamt = 5'd0;
				2: shamt = 5'd2;
				3: shamt = 5'd3;
				default: shamt = 5'd7;
			endcase
			drive_instr((i == 5) ? 3'd5 : vec_alu_pkg::LOGIC, shamt, vec_alu_pkg::CONST,
				vec_alu_pkg::CONST, vec_alu_pkg::CONST, 1'b1, 1'b0, 1'b0);
			if (i == 0) const_a = '0;
			wait_commit();
		end

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- vec_alu.f
+incdir+include
source/vec_alu_pkg.sv
source/lane_fifo.sv
source/vec_regfile.sv
source/temp_buf.sv
source/vec_alu.sv
source/vec_alu_top.sv
verif/tb_clkgen.sv
verif/tb_vec_alu_top.sv

//--- Makefile
# Verilator flow for the vector ALU stage

VERILATOR ?= verilator
FLIST     ?= vec_alu.f
TB_TOP    ?= tb_vec_alu_top
RTL_TOP   ?= vec_alu_top
BUILD_DIR ?= obj_dir
SIM_EXE   ?= sim_vec_alu
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing --assert -f $(FLIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -o $(SIM_EXE)
	@out="$$(./$(BUILD_DIR)/$(SIM_EXE) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
